// File: Makefile
SIM      := verilator
TOP      := tb_mem_bridge
FILELIST := mem_bridge.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: mem_bridge.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/bus_pkg.sv
verilog/bus_arbiter.sv
verilog/axi_read_chan.sv
verilog/axi_write_chan.sv
verilog/mem_bridge_top.sv
tests/tb_clk_gen.sv
tests/mem_bridge_sva.sv
tests/tb_mem_bridge.sv

// File: tests/mem_bridge_sva.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module mem_bridge_sva
  import bus_pkg::*;
(
  input logic                  clk,
  input logic                  rst_i,
  input owner_t                owner_i,
  input logic                  arvalid_i,
  input logic                  arready_i,
  input logic [`MB_ADDR_W-1:0] araddr_i,
  input logic [`MB_ID_W-1:0]   arid_i,
  input logic                  awvalid_i,
  input logic                  awready_i,
  input logic [`MB_ADDR_W-1:0] awaddr_i,
  input logic [`MB_ID_W-1:0]   awid_i,
  input logic                  wvalid_i,
  input logic                  wready_i,
  input logic [`MB_DATA_W-1:0] wdata_i,
  input logic [`MB_STRB_W-1:0] wstrb_i,
  input logic                  rready_i,
  input logic                  bready_i,
  input logic                  if_done_i,
  input logic                  d_done_i
);

  int fail_cnt = 0; // failed assertion count

  // valid and payload hold until the slave takes them
  ar_hold: assert property (@(posedge clk) disable iff (rst_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arid_i))
    else begin
      fail_cnt++;
      $error("ar channel dropped or changed before arready");
    end

  aw_hold: assert property (@(posedge clk) disable iff (rst_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awid_i))
    else begin
      fail_cnt++;
      $error("aw channel dropped or changed before awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (rst_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else begin
      fail_cnt++;
      $error("w channel dropped or changed before wready");
    end

  reset_quiet: assert property (@(posedge clk)
    rst_i |=> !(arvalid_i || awvalid_i || wvalid_i || rready_i || bready_i
                || if_done_i || d_done_i))
    else begin
      fail_cnt++;
      $error("valid, ready or done high after reset");
    end

  // one done strobe per request
  done_pulse: assert property (@(posedge clk) disable iff (rst_i)
    (if_done_i || d_done_i) |=> !(if_done_i || d_done_i))
    else begin
      fail_cnt++;
      $error("done strobe longer than one cycle");
    end

  bus_owned: assert property (@(posedge clk) disable iff (rst_i)
    (arvalid_i || awvalid_i) |-> owner_i != OWN_NONE)
    else begin
      fail_cnt++;
      $error("axi address issued with no bus owner");
    end

endmodule

bind mem_bridge_top mem_bridge_sva u_sva (
  .clk       (clk),
  .rst_i     (rst_i),
  .owner_i   (u_arb.owner),
  .arvalid_i (arvalid_o),
  .arready_i (arready_i),
  .araddr_i  (araddr_o),
  .arid_i    (arid_o),
  .awvalid_i (awvalid_o),
  .awready_i (awready_i),
  .awaddr_i  (awaddr_o),
  .awid_i    (awid_o),
  .wvalid_i  (wvalid_o),
  .wready_i  (wready_i),
  .wdata_i   (wdata_o),
  .wstrb_i   (wstrb_o),
  .rready_i  (rready_o),
  .bready_i  (bready_o),
  .if_done_i (if_done_o),
  .d_done_i  (d_done_o)
);

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 20; // 40 ns clock
  localparam int RST_CYCLES  = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release on a falling edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: tests/tb_mem_bridge.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module tb_mem_bridge
  import axi_pkg::*;
  import bus_pkg::*;
();

  localparam int TIMEOUT = 60; // cycles allowed per wait
  localparam logic [1:0] K_FETCH  = 2'd0;
  localparam logic [1:0] K_DREAD  = 2'd1;
  localparam logic [1:0] K_DWRITE = 2'd2;
  localparam logic [1:0] K_BOTH   = 2'd3; // fetch and data read in the same cycle
  localparam logic [`MB_ID_W-1:0] ID_FETCH = `MB_ID_FETCH;
  localparam logic [`MB_ID_W-1:0] ID_DATA  = `MB_ID_DATA;
  localparam axi_size_t WORD_CODE = 3'd2; // 4 bytes per beat

  typedef struct packed {
    logic [1:0]            kind;
    logic [`MB_ADDR_W-1:0] addr;
    req_size_t             size;
    logic [`MB_STRB_W-1:0] strb;
    logic [`MB_DATA_W-1:0] wdata;
    logic [`MB_DATA_W-1:0] rdata;
    axi_resp_t             resp;
  } entry_t;

  logic clk;
  logic rst_i;
  logic if_req_i, if_done_o, if_err_o, d_req_i, d_we_i, d_done_o, d_err_o;
  logic [`MB_ADDR_W-1:0] if_addr_i, d_addr_i, awaddr_o, araddr_o;
  logic [`MB_DATA_W-1:0] if_rdata_o, d_wdata_i, d_rdata_o, wdata_o, rdata_i;
  logic [`MB_STRB_W-1:0] d_wstrb_i, wstrb_o;
  req_size_t             d_size_i;
  logic awready_i, awvalid_o, wready_i, wvalid_o, wlast_o, bready_o, bvalid_i;
  logic arready_i, arvalid_o, rready_o, rvalid_i;
  logic [`MB_ID_W-1:0]   awid_o, arid_o;
  logic [7:0]            awlen_o, arlen_o;
  axi_size_t             awsize_o, arsize_o;
  axi_burst_t            awburst_o, arburst_o;
  axi_resp_t             bresp_i, rresp_i;

  entry_t                tbl[$];
  // what the slave model saw on the address channels
  logic [`MB_ADDR_W-1:0] ar_addr_q[$];
  logic [`MB_ID_W-1:0]   ar_id_q[$];
  axi_size_t             ar_size_q[$];
  logic [7:0]            ar_len_q[$];
  axi_burst_t            ar_burst_q[$];
  logic [`MB_ADDR_W-1:0] aw_addr;
  logic [`MB_ID_W-1:0]   aw_id;
  axi_size_t             aw_size;
  logic [7:0]            aw_len;
  axi_burst_t            aw_burst;
  logic [`MB_DATA_W-1:0] w_data;
  logic [`MB_STRB_W-1:0] w_strb;
  logic                  w_last;
  logic                  b_seen; // B handshake done for the current write

  tb_clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  mem_bridge_top u_dut (.*);

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic tick(inout int n, input string what);
    @(negedge clk);
    n++;
    if (n > TIMEOUT) begin
      $display("timeout while waiting for %s", what);
      stop_run();
    end
  endtask

  // axi size code is log2 of the bytes per beat
  function automatic axi_size_t size_code(input req_size_t s);
    case (s)
      SZ_BYTE: return 3'd0;
      SZ_HALF: return 3'd1;
      default: return 3'd2;
    endcase
  endfunction

  task automatic check_addr(input string name, input logic [`MB_ADDR_W-1:0] got,
                            input logic [`MB_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input logic [`MB_DATA_W-1:0] got,
                            input logic [`MB_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_strb(input string name, input logic [`MB_STRB_W-1:0] got,
                            input logic [`MB_STRB_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_size(input string name, input axi_size_t got, input axi_size_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_len(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_burst(input string name, input axi_burst_t got,
                             input axi_burst_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_id(input string name, input logic [`MB_ID_W-1:0] got,
                          input logic [`MB_ID_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_ar(input int idx, input logic [`MB_ADDR_W-1:0] addr,
                          input logic [`MB_ID_W-1:0] id, input axi_size_t size);
    check_addr("araddr_o", ar_addr_q[idx], addr);
    check_id("arid_o", ar_id_q[idx], id);
    check_size("arsize_o", ar_size_q[idx], size);
    check_len("arlen_o", ar_len_q[idx], 8'd0);
    check_burst("arburst_o", ar_burst_q[idx], INCR);
  endtask

  task automatic add_entry(input logic [1:0] kind, input logic [`MB_ADDR_W-1:0] addr,
                           input req_size_t size, input logic [`MB_STRB_W-1:0] strb,
                           input logic [`MB_DATA_W-1:0] wdata,
                           input logic [`MB_DATA_W-1:0] rdata, input axi_resp_t resp);
    entry_t e;
    e.kind  = kind;
    e.addr  = addr;
    e.size  = size;
    e.strb  = strb;
    e.wdata = wdata;
    e.rdata = rdata;
    e.resp  = resp;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    add_entry(K_FETCH,  32'h0000_1000, SZ_WORD, 4'hf, 32'h0,          32'h1357_9bdf, OKAY);
    add_entry(K_DREAD,  32'h2000_0003, SZ_BYTE, 4'h8, 32'h0,          32'h0000_00a5, OKAY);
    add_entry(K_DREAD,  32'h2000_0006, SZ_HALF, 4'hc, 32'h0,          32'h0000_beef, OKAY);
    add_entry(K_DWRITE, 32'h2000_0010, SZ_WORD, 4'hf, 32'hdead_beef, 32'h0,          OKAY);
    add_entry(K_DWRITE, 32'h2000_0021, SZ_BYTE, 4'h2, 32'h0000_5a00, 32'h0,          OKAY);
    add_entry(K_FETCH,  32'h0000_1004, SZ_WORD, 4'hf, 32'h0,          32'h0bad_f00d, SLVERR);
    add_entry(K_DREAD,  32'h3000_0000, SZ_WORD, 4'hf, 32'h0,          32'h7777_1111, DECERR);
    add_entry(K_DWRITE, 32'h3000_0004, SZ_HALF, 4'h3, 32'h0000_1234, 32'h0,          SLVERR);
    add_entry(K_BOTH,   32'h2000_0040, SZ_WORD, 4'hf, 32'h0,          32'hcafe_f00d, OKAY);
    add_entry(K_BOTH,   32'h2000_0052, SZ_HALF, 4'hc, 32'h0,          32'h0000_4321, OKAY);
  endtask

  // slave side of one read, data picked by the arid it sees
  task automatic serve_read(input logic [`MB_DATA_W-1:0] d_val,
                            input logic [`MB_DATA_W-1:0] f_val, input axi_resp_t resp);
    int n;
    logic [`MB_ID_W-1:0] id;
    n = 0;
    while (!arvalid_o) tick(n, "arvalid_o");
    repeat ($urandom_range(3, 0)) @(negedge clk);
    id = arid_o;
    ar_addr_q.push_back(araddr_o);
    ar_id_q.push_back(arid_o);
    ar_size_q.push_back(arsize_o);
    ar_len_q.push_back(arlen_o);
    ar_burst_q.push_back(arburst_o);
    arready_i = 1'b1;
    @(negedge clk);
    arready_i = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge clk);
    rvalid_i = 1'b1;
    rdata_i  = (id == ID_DATA) ? d_val : f_val;
    rresp_i  = resp;
    n = 0;
    while (!rready_o) tick(n, "rready_o");
    @(negedge clk);
    rvalid_i = 1'b0;
  endtask

  task automatic serve_write(input axi_resp_t resp);
    int na;
    int nw;
    int nb;
    na = 0;
    nw = 0;
    nb = 0;
    fork
      begin
        while (!awvalid_o) tick(na, "awvalid_o");
        repeat ($urandom_range(3, 0)) @(negedge clk);
        aw_addr   = awaddr_o;
        aw_id     = awid_o;
        aw_size   = awsize_o;
        aw_len    = awlen_o;
        aw_burst  = awburst_o;
        awready_i = 1'b1;
        @(negedge clk);
        awready_i = 1'b0;
      end
      begin
        while (!wvalid_o) tick(nw, "wvalid_o");
        repeat ($urandom_range(3, 0)) @(negedge clk);
        w_data   = wdata_o;
        w_strb   = wstrb_o;
        w_last   = wlast_o;
        wready_i = 1'b1;
        @(negedge clk);
        wready_i = 1'b0;
      end
    join
    while (!bready_o) tick(nb, "bready_o");
    repeat ($urandom_range(3, 0)) @(negedge clk);
    bvalid_i = 1'b1;
    bresp_i  = resp;
    @(negedge clk); // bready held, so handshake on the edge just passed
    bvalid_i = 1'b0;
    b_seen   = 1'b1;
  endtask

  task automatic do_fetch(input logic [`MB_ADDR_W-1:0] addr,
                          input logic [`MB_DATA_W-1:0] exp_data, input logic exp_err);
    int n;
    n = 0;
    if_req_i  = 1'b1;
    if_addr_i = addr;
    tick(n, "if_done_o");
    while (!if_done_o) tick(n, "if_done_o");
    check_data("if_rdata_o", if_rdata_o, exp_data);
    check_bit("if_err_o", if_err_o, exp_err);
    if_req_i = 1'b0;
  endtask

  task automatic do_data(input entry_t e, input logic exp_err);
    int n;
    n = 0;
    d_req_i   = 1'b1;
    d_we_i    = (e.kind == K_DWRITE);
    d_addr_i  = e.addr;
    d_size_i  = e.size;
    d_wstrb_i = e.strb;
    d_wdata_i = e.wdata;
    tick(n, "d_done_o");
    while (!d_done_o) tick(n, "d_done_o");
    if (e.kind == K_DWRITE)
      check_bit("B handshake before d_done_o", b_seen, 1'b1);
    else
      check_data("d_rdata_o", d_rdata_o, e.rdata);
    check_bit("d_err_o", d_err_o, exp_err);
    d_req_i = 1'b0;
  endtask

  initial begin
    int n;
    entry_t e;
    logic exp_err;
    void'($urandom(88551));
    if_req_i  = 1'b0;
    if_addr_i = '0;
    d_req_i   = 1'b0;
    d_we_i    = 1'b0;
    d_addr_i  = '0;
    d_wdata_i = '0;
    d_wstrb_i = '0;
    d_size_i  = SZ_WORD;
    awready_i = 1'b0;
    wready_i  = 1'b0;
    bvalid_i  = 1'b0;
    bresp_i   = OKAY;
    arready_i = 1'b0;
    rvalid_i  = 1'b0;
    rdata_i   = '0;
    rresp_i   = OKAY;
    b_seen    = 1'b0;
    build_table();
    n = 0;
    tick(n, "reset release");
    while (rst_i) tick(n, "reset release");
    check_bit("arvalid_o", arvalid_o, 1'b0);
    check_bit("awvalid_o", awvalid_o, 1'b0);
    check_bit("wvalid_o", wvalid_o, 1'b0);
    check_bit("rready_o", rready_o, 1'b0);
    check_bit("bready_o", bready_o, 1'b0);
    check_bit("if_done_o", if_done_o, 1'b0);
    check_bit("d_done_o", d_done_o, 1'b0);
    foreach (tbl[i]) begin
      e       = tbl[i];
      exp_err = (e.resp != OKAY);
      b_seen  = 1'b0;
      ar_addr_q.delete();
      ar_id_q.delete();
      ar_size_q.delete();
      ar_len_q.delete();
      ar_burst_q.delete();
      @(negedge clk);
      case (e.kind)
        K_FETCH: begin
          fork
            do_fetch(e.addr, e.rdata, exp_err);
            serve_read(e.rdata, e.rdata, e.resp);
          join
          check_ar(0, e.addr, ID_FETCH, WORD_CODE);
        end
        K_DREAD: begin
          fork
            do_data(e, exp_err);
            serve_read(e.rdata, e.rdata, e.resp);
          join
          check_ar(0, e.addr, ID_DATA, size_code(e.size));
        end
        K_DWRITE: begin
          fork
            do_data(e, exp_err);
            serve_write(e.resp);
          join
          check_addr("awaddr_o", aw_addr, e.addr);
          check_id("awid_o", aw_id, ID_DATA);
          check_size("awsize_o", aw_size, size_code(e.size));
          check_len("awlen_o", aw_len, 8'd0);
          check_burst("awburst_o", aw_burst, INCR);
          check_data("wdata_o", w_data, e.wdata);
          check_strb("wstrb_o", w_strb, e.strb);
          check_bit("wlast_o", w_last, 1'b1);
        end
        default: begin
          // fetch sits at its own address and reads inverted data
          fork
            do_fetch(e.addr + 32'h100, ~e.rdata, exp_err);
            do_data(e, exp_err);
            begin
              serve_read(e.rdata, ~e.rdata, e.resp);
              serve_read(e.rdata, ~e.rdata, e.resp);
            end
          join
          check_ar(0, e.addr, ID_DATA, size_code(e.size)); // data side first
          check_ar(1, e.addr + 32'h100, ID_FETCH, WORD_CODE);
        end
      endcase
    end
    if (u_dut.u_sva.fail_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("bound assertions reported %0d failures", u_dut.u_sva.fail_cnt);
      stop_run();
    end
  end

endmodule

// File: verilog/axi_pkg.sv
package axi_pkg;

  // size code, bytes per beat = 2**size
  typedef logic [2:0] axi_size_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10 // never issued here
  } axi_burst_t;

  // slave response codes, anything but OKAY counts as an error
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

endpackage

// File: verilog/axi_read_chan.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module axi_read_chan
  import axi_pkg::*;
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  start_i,
  input  logic [`MB_ADDR_W-1:0] addr_i,
  input  req_size_t             size_i,
  input  logic [`MB_ID_W-1:0]   id_i,
  input  logic                  arready_i,
  input  logic                  rvalid_i,
  input  logic [`MB_DATA_W-1:0] rdata_i,
  input  axi_resp_t             rresp_i,
  output logic                  arvalid_o,
  output logic [`MB_ADDR_W-1:0] araddr_o,
  output logic [`MB_ID_W-1:0]   arid_o,
  output axi_size_t             arsize_o,
  output logic [7:0]            arlen_o,
  output axi_burst_t            arburst_o,
  output logic                  rready_o,
  output logic                  done_o,
  output logic [`MB_DATA_W-1:0] rdata_o,
  output logic                  err_o
);

  logic [`MB_ADDR_W-1:0] addr_q;
  req_size_t             size_q;
  logic [`MB_ID_W-1:0]   id_q;
  logic                  r_hs;

  assign r_hs = rready_o && rvalid_i;

  assign araddr_o  = addr_q;
  assign arid_o    = id_q;
  assign arsize_o  = axi_size_t'(size_q); // same code points
  assign arlen_o   = 8'd0;                // single beat
  assign arburst_o = INCR;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      arvalid_o <= 1'b0;
      rready_o  <= 1'b0;
      done_o    <= 1'b0;
      err_o     <= 1'b0;
    end else begin
      done_o <= 1'b0;
      err_o  <= 1'b0;
      if (start_i) begin
        arvalid_o <= 1'b1;
        rready_o  <= 1'b1; // ready for data as soon as address goes out
      end else begin
        if (arvalid_o && arready_i)
          arvalid_o <= 1'b0;
        if (r_hs) begin
          rready_o <= 1'b0;
          done_o   <= 1'b1;
          err_o    <= (rresp_i != OKAY);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      addr_q <= addr_i;
      size_q <= size_i;
      id_q   <= id_i;
    end
    if (r_hs)
      rdata_o <= rdata_i;
  end

endmodule

// File: verilog/axi_write_chan.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module axi_write_chan
  import axi_pkg::*;
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  start_i,
  input  logic [`MB_ADDR_W-1:0] addr_i,
  input  req_size_t             size_i,
  input  logic [`MB_ID_W-1:0]   id_i,
  input  logic [`MB_DATA_W-1:0] wdata_i,
  input  logic [`MB_STRB_W-1:0] strb_i,
  input  logic                  awready_i,
  input  logic                  wready_i,
  input  logic                  bvalid_i,
  input  axi_resp_t             bresp_i,
  output logic                  awvalid_o,
  output logic [`MB_ADDR_W-1:0] awaddr_o,
  output logic [`MB_ID_W-1:0]   awid_o,
  output axi_size_t             awsize_o,
  output logic [7:0]            awlen_o,
  output axi_burst_t            awburst_o,
  output logic                  wvalid_o,
  output logic [`MB_DATA_W-1:0] wdata_o,
  output logic [`MB_STRB_W-1:0] wstrb_o,
  output logic                  wlast_o,
  output logic                  bready_o,
  output logic                  done_o,
  output logic                  err_o
);

  logic                  busy;
  logic                  aw_ok;
  logic                  w_ok;
  logic [`MB_ADDR_W-1:0] addr_q;
  req_size_t             size_q;
  logic [`MB_ID_W-1:0]   id_q;

  // address or data phase finished, or finishing this cycle
  assign aw_ok = !awvalid_o || awready_i;
  assign w_ok  = !wvalid_o || wready_i;

  assign awaddr_o  = addr_q;
  assign awid_o    = id_q;
  assign awsize_o  = axi_size_t'(size_q);
  assign awlen_o   = 8'd0;
  assign awburst_o = INCR;
  assign wlast_o   = 1'b1; // every burst is one beat

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy      <= 1'b0;
      awvalid_o <= 1'b0;
      wvalid_o  <= 1'b0;
      bready_o  <= 1'b0;
      done_o    <= 1'b0;
      err_o     <= 1'b0;
    end else begin
      done_o <= 1'b0;
      err_o  <= 1'b0;
      if (start_i) begin
        busy      <= 1'b1;
        awvalid_o <= 1'b1;
        wvalid_o  <= 1'b1;
      end else if (busy) begin
        if (awready_i)
          awvalid_o <= 1'b0;
        if (wready_i)
          wvalid_o <= 1'b0;
        // response phase opens once both aw and w are through
        if (!bready_o && aw_ok && w_ok)
          bready_o <= 1'b1;
        if (bready_o && bvalid_i) begin
          bready_o <= 1'b0;
          busy     <= 1'b0;
          done_o   <= 1'b1;
          err_o    <= (bresp_i != OKAY);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      addr_q  <= addr_i;
      size_q  <= size_i;
      id_q    <= id_i;
      wdata_o <= wdata_i;
      wstrb_o <= strb_i;
    end
  end

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module bus_arbiter
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  if_req_i,
  input  logic [`MB_ADDR_W-1:0] if_addr_i,
  input  logic                  d_req_i,
  input  logic                  d_we_i,
  input  logic [`MB_ADDR_W-1:0] d_addr_i,
  input  req_size_t             d_size_i,
  input  logic [`MB_STRB_W-1:0] d_wstrb_i,
  input  logic                  rd_done_i,
  input  logic                  wr_done_i,
  input  logic                  err_i,
  output logic                  if_done_o,
  output logic                  d_done_o,
  output logic                  if_err_o,
  output logic                  d_err_o,
  output logic                  rd_start_o,
  output logic                  wr_start_o,
  output logic [`MB_ADDR_W-1:0] addr_o,
  output req_size_t             size_o,
  output logic [`MB_STRB_W-1:0] strb_o,
  output logic [`MB_ID_W-1:0]   id_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} state_t;

  localparam logic [`MB_ID_W-1:0] ID_FETCH = `MB_ID_FETCH;
  localparam logic [`MB_ID_W-1:0] ID_DATA  = `MB_ID_DATA;

  state_t state;
  owner_t owner;
  logic   grant_ok;
  logic   ch_done;

  // requester still holds req during its done cycle, so skip that one
  assign grant_ok = (state == ST_IDLE) && !if_done_o && !d_done_o;
  assign ch_done  = ((state == ST_READ) && rd_done_i) || ((state == ST_WRITE) && wr_done_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state      <= ST_IDLE;
      owner      <= OWN_NONE;
      rd_start_o <= 1'b0;
      wr_start_o <= 1'b0;
      if_done_o  <= 1'b0;
      d_done_o   <= 1'b0;
      if_err_o   <= 1'b0;
      d_err_o    <= 1'b0;
    end else begin
      rd_start_o <= 1'b0;
      wr_start_o <= 1'b0;
      if_done_o  <= 1'b0;
      d_done_o   <= 1'b0;
      if_err_o   <= 1'b0;
      d_err_o    <= 1'b0;
      if (grant_ok && d_req_i) begin // data side wins
        state      <= d_we_i ? ST_WRITE : ST_READ;
        owner      <= OWN_DATA;
        rd_start_o <= !d_we_i;
        wr_start_o <= d_we_i;
      end else if (grant_ok && if_req_i) begin
        state      <= ST_READ;
        owner      <= OWN_FETCH;
        rd_start_o <= 1'b1;
      end else if (ch_done) begin
        // hand completion back to whoever owns the port
        state     <= ST_IDLE;
        owner     <= OWN_NONE;
        if_done_o <= (owner == OWN_FETCH);
        d_done_o  <= (owner == OWN_DATA);
        if_err_o  <= (owner == OWN_FETCH) && err_i;
        d_err_o   <= (owner == OWN_DATA) && err_i;
      end
    end
  end

  // request fields, latched with the grant
  always_ff @(posedge clk) begin
    if (grant_ok && d_req_i) begin
      addr_o <= d_addr_i;
      size_o <= d_size_i;
      strb_o <= d_wstrb_i;
      id_o   <= ID_DATA;
    end else if (grant_ok && if_req_i) begin
      addr_o <= if_addr_i;
      size_o <= SZ_WORD; // fetch is always a full word
      strb_o <= '1;
      id_o   <= ID_FETCH;
    end
  end

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

  // access size from the data requester
  // encoded the same as the axi size field
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } req_size_t;

  // who currently holds the master port
  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_FETCH = 2'd1,
    OWN_DATA  = 2'd2
  } owner_t;

endpackage

// File: verilog/mem_bridge_cfg.svh
`ifndef MEM_BRIDGE_CFG_SVH
`define MEM_BRIDGE_CFG_SVH

// bus widths shared by the whole bridge
`define MB_ADDR_W 32
`define MB_DATA_W 32
`define MB_STRB_W 4 // one strobe per byte lane

// axi transaction ids
`define MB_ID_W 4
`define MB_ID_FETCH 0 // instruction fetch reads
`define MB_ID_DATA 1  // load/store accesses

`endif

// File: verilog/mem_bridge_top.sv
`timescale 1ns/1ns
`include "mem_bridge_cfg.svh"

module mem_bridge_top
  import axi_pkg::*;
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  // fetch requester
  input  logic                  if_req_i,
  input  logic [`MB_ADDR_W-1:0] if_addr_i,
  output logic                  if_done_o,
  output logic [`MB_DATA_W-1:0] if_rdata_o,
  output logic                  if_err_o,
  // data requester
  input  logic                  d_req_i,
  input  logic                  d_we_i,
  input  logic [`MB_ADDR_W-1:0] d_addr_i,
  input  logic [`MB_DATA_W-1:0] d_wdata_i,
  input  logic [`MB_STRB_W-1:0] d_wstrb_i,
  input  req_size_t             d_size_i,
  output logic                  d_done_o,
  output logic [`MB_DATA_W-1:0] d_rdata_o,
  output logic                  d_err_o,
  // axi write address
  input  logic                  awready_i,
  output logic                  awvalid_o,
  output logic [`MB_ADDR_W-1:0] awaddr_o,
  output logic [`MB_ID_W-1:0]   awid_o,
  output logic [7:0]            awlen_o,
  output axi_size_t             awsize_o,
  output axi_burst_t            awburst_o,
  // axi write data and response
  input  logic                  wready_i,
  output logic                  wvalid_o,
  output logic [`MB_DATA_W-1:0] wdata_o,
  output logic [`MB_STRB_W-1:0] wstrb_o,
  output logic                  wlast_o,
  output logic                  bready_o,
  input  logic                  bvalid_i,
  input  axi_resp_t             bresp_i,
  // axi read address and data
  input  logic                  arready_i,
  output logic                  arvalid_o,
  output logic [`MB_ADDR_W-1:0] araddr_o,
  output logic [`MB_ID_W-1:0]   arid_o,
  output logic [7:0]            arlen_o,
  output axi_size_t             arsize_o,
  output axi_burst_t            arburst_o,
  output logic                  rready_o,
  input  logic                  rvalid_i,
  input  axi_resp_t             rresp_i,
  input  logic [`MB_DATA_W-1:0] rdata_i
);

  logic                  rd_start;
  logic                  wr_start;
  logic                  rd_done;
  logic                  wr_done;
  logic                  rd_err;
  logic                  wr_err;
  logic                  ch_err;
  logic [`MB_ADDR_W-1:0] arb_addr;
  req_size_t             arb_size;
  logic [`MB_STRB_W-1:0] arb_strb;
  logic [`MB_ID_W-1:0]   arb_id;
  logic [`MB_DATA_W-1:0] rd_rdata;

  assign ch_err     = rd_err | wr_err; // each is only high with its own done
  assign if_rdata_o = rd_rdata;
  assign d_rdata_o  = rd_rdata;

  bus_arbiter u_arb (
    .clk        (clk),
    .rst_i      (rst_i),
    .if_req_i   (if_req_i),
    .if_addr_i  (if_addr_i),
    .d_req_i    (d_req_i),
    .d_we_i     (d_we_i),
    .d_addr_i   (d_addr_i),
    .d_size_i   (d_size_i),
    .d_wstrb_i  (d_wstrb_i),
    .rd_done_i  (rd_done),
    .wr_done_i  (wr_done),
    .err_i      (ch_err),
    .if_done_o  (if_done_o),
    .d_done_o   (d_done_o),
    .if_err_o   (if_err_o),
    .d_err_o    (d_err_o),
    .rd_start_o (rd_start),
    .wr_start_o (wr_start),
    .addr_o     (arb_addr),
    .size_o     (arb_size),
    .strb_o     (arb_strb),
    .id_o       (arb_id)
  );

  axi_read_chan u_rd (
    .clk       (clk),
    .rst_i     (rst_i),
    .start_i   (rd_start),
    .addr_i    (arb_addr),
    .size_i    (arb_size),
    .id_i      (arb_id),
    .arready_i (arready_i),
    .rvalid_i  (rvalid_i),
    .rdata_i   (rdata_i),
    .rresp_i   (rresp_i),
    .arvalid_o (arvalid_o),
    .araddr_o  (araddr_o),
    .arid_o    (arid_o),
    .arsize_o  (arsize_o),
    .arlen_o   (arlen_o),
    .arburst_o (arburst_o),
    .rready_o  (rready_o),
    .done_o    (rd_done),
    .rdata_o   (rd_rdata),
    .err_o     (rd_err)
  );

  axi_write_chan u_wr (
    .clk       (clk),
    .rst_i     (rst_i),
    .start_i   (wr_start),
    .addr_i    (arb_addr),
    .size_i    (arb_size),
    .id_i      (arb_id),
    .wdata_i   (d_wdata_i), // only the data side ever writes
    .strb_i    (arb_strb),
    .awready_i (awready_i),
    .wready_i  (wready_i),
    .bvalid_i  (bvalid_i),
    .bresp_i   (bresp_i),
    .awvalid_o (awvalid_o),
    .awaddr_o  (awaddr_o),
    .awid_o    (awid_o),
    .awsize_o  (awsize_o),
    .awlen_o   (awlen_o),
    .awburst_o (awburst_o),
    .wvalid_o  (wvalid_o),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .wlast_o   (wlast_o),
    .bready_o  (bready_o),
    .done_o    (wr_done),
    .err_o     (wr_err)
  );

endmodule
